/* logic/uartPkg.sv */
/*
 * UART peripheral shared definitions
 * frame format, FIFO sizing, baud divisor width and reset value,
 * Wishbone register map, status flag positions and the FSM state
 * codes used by both serial engines
 */

package uartPkg;

	// frame format
	localparam int dataBits = 8;		// payload bits per frame
	localparam int sbTick = 16;		// ticks in the stop bit
	localparam int tickLen = 4;		// counts 16 oversampling ticks
	localparam int bitCntLen = 3;		// counts data bits

	// fifo sizing
	localparam int fifoDepth = 16;
	localparam int fifoAddrLen = 4;
	localparam int fifoCntLen = fifoAddrLen + 1;	// 0..fifoDepth

	// baud divisor
	localparam int divLen = 16;
	localparam logic [divLen-1:0] divReset = 16'd4;	// short frames in sim

	// wishbone register map
	localparam int regAddrLen = 2;
	localparam logic [regAddrLen-1:0] addrData = 2'd0;	// rx pop / tx push
	localparam logic [regAddrLen-1:0] addrStat = 2'd1;	// flags, read clears overrun
	localparam logic [regAddrLen-1:0] addrDiv = 2'd2;	// divisor low byte

	// status bit positions, bits 7:5 read zero
	localparam int statRxEmpty = 0;
	localparam int statRxFull = 1;
	localparam int statTxEmpty = 2;
	localparam int statTxFull = 3;
	localparam int statOverrun = 4;

	// shared FSM state codes for rx and tx
	localparam logic [1:0] stIdle = 2'b00;
	localparam logic [1:0] stStart = 2'b01;
	localparam logic [1:0] stData = 2'b10;
	localparam logic [1:0] stStop = 2'b11;

endpackage

/* logic/baudGen.sv */
/*
 * Baud tick generator
 * down counter that pulses sTick once every div clocks,
 * giving the 16x oversampling rate for both serial engines
 */

`timescale 1ns/100ps

module baudGen import uartPkg::*; (
	input logic clk,
	input logic reset,
	input logic [divLen-1:0] div,		// clocks per tick
	output logic sTick
);

	logic [divLen-1:0] cnt;

	// reload on wrap so a new divisor only lands at the next tick
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt <= '0;
			sTick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt <= div - divLen'(1);	// div clocks per period
			sTick <= 1'b1;
		end
		else
		begin
			cnt <= cnt - divLen'(1);
			sTick <= 1'b0;
		end
	end

endmodule

/* logic/uartRec.sv */
/*
 * UART receiver
 * oversampling FSM, finds the middle of the start bit, then samples
 * each data bit at its centre and shifts it in LSB first;
 * pulses rxDoneTick for one cycle at the end of the stop bit
 */

`timescale 1ns/100ps

module uartRec import uartPkg::*; (
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic rx,
	output logic rxDoneTick,
	output logic [dataBits-1:0] dOut
);

	logic [1:0] stateReg, stateNext;
	logic [tickLen-1:0] sReg, sNext;	// tick counter within a bit
	logic [bitCntLen-1:0] nReg, nNext;	// data bit index
	logic [dataBits-1:0] bReg, bNext;	// shift register
	logic rxMeta, rxSync;			// line synchronizer

	// two flops on the async line, idle level is high
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= stIdle;
			sReg <= '0;
			nReg <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;		// payload only

	////////////////////////////////////////////////////////////
	// next state logic
	////////////////////////////////////////////////////////////
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;
		case (stateReg)
			stIdle:
				if (!rxSync)		// falling edge of start bit
				begin
					stateNext = stStart;
					sNext = '0;
				end
			stStart:
				if (sTick)
				begin
					if (sReg == tickLen'(7))	// middle of start bit
					begin
						stateNext = stData;
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + tickLen'(1);
				end
			stData:
				if (sTick)
				begin
					if (sReg == tickLen'(15))	// middle of next data bit
					begin
						sNext = '0;
						bNext = {rxSync, bReg[dataBits-1:1]};	// LSB first
						if (nReg == bitCntLen'(dataBits - 1))
							stateNext = stStop;
						else
							nNext = nReg + bitCntLen'(1);
					end
					else
						sNext = sReg + tickLen'(1);
				end
			default:		// stStop
				if (sTick)
				begin
					if (sReg == tickLen'(sbTick - 1))
					begin
						stateNext = stIdle;
						rxDoneTick = 1'b1;	// byte complete
					end
					else
						sNext = sReg + tickLen'(1);
				end
		endcase
	end

	assign dOut = bReg;

	// done pulse is never stretched
	doneSingle: assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |=> !rxDoneTick);

endmodule

/* logic/uartTrans.sv */
/*
 * UART transmitter
 * pops a byte from the TX FIFO when idle, then sends start bit,
 * 8 data bits LSB first and one stop bit, 16 ticks each;
 * the line idles high
 */

`timescale 1ns/100ps

module uartTrans import uartPkg::*; (
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic txEmpty,
	input logic [dataBits-1:0] dIn,		// head of tx fifo
	output logic txPop,
	output logic tx
);

	logic [1:0] stateReg, stateNext;
	logic [tickLen-1:0] sReg, sNext;
	logic [bitCntLen-1:0] nReg, nNext;
	logic [dataBits-1:0] bReg, bNext;
	logic txReg, txNext;			// registered line, no glitches

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= stIdle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		txPop = 1'b0;
		case (stateReg)
			stIdle:
			begin
				txNext = 1'b1;
				if (!txEmpty)
				begin
					txPop = 1'b1;		// latch and pop together
					bNext = dIn;
					sNext = '0;
					stateNext = stStart;
				end
			end
			stStart:
			begin
				txNext = 1'b0;
				if (sTick)
				begin
					if (sReg == tickLen'(15))
					begin
						stateNext = stData;
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + tickLen'(1);
				end
			end
			stData:
			begin
				txNext = bReg[0];	// LSB out first
				if (sTick)
				begin
					if (sReg == tickLen'(15))
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == bitCntLen'(dataBits - 1))
							stateNext = stStop;
						else
							nNext = nReg + bitCntLen'(1);
					end
					else
						sNext = sReg + tickLen'(1);
				end
			end
			default:		// stStop
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == tickLen'(sbTick - 1))
						stateNext = stIdle;	// one idle cycle before next frame
					else
						sNext = sReg + tickLen'(1);
				end
			end
		endcase
	end

	assign tx = txReg;

	// registered line lags state by a cycle, still high on every idle cycle
	idleLineHigh: assert property (@(posedge clk) disable iff (reset)
		(stateReg == stIdle) |-> tx);

endmodule

/* logic/uartFifo.sv */
/*
 * Synchronous FIFO, 16 x 8
 * register array with read/write pointers and an occupancy count;
 * dOut always shows the head entry
 */

`timescale 1ns/100ps

module uartFifo import uartPkg::*; (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input logic [dataBits-1:0] dIn,
	output logic [dataBits-1:0] dOut,
	output logic empty,
	output logic full
);

	logic [dataBits-1:0] mem [fifoDepth];
	logic [fifoAddrLen-1:0] wrPtr, rdPtr;	// wrap naturally at depth 16
	logic [fifoCntLen-1:0] count;
	logic doPush, doPop;

	assign doPush = push && !full;		// drop when full
	assign doPop = pop && !empty;		// ignore when empty

	always_ff @(posedge clk)
		if (doPush)
			mem[wrPtr] <= dIn;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + fifoAddrLen'(1);
			if (doPop)
				rdPtr <= rdPtr + fifoAddrLen'(1);
			// both at once leaves count alone
			if (doPush && !doPop)
				count <= count + fifoCntLen'(1);
			else if (doPop && !doPush)
				count <= count - fifoCntLen'(1);
		end
	end

	assign dOut = mem[rdPtr];
	assign empty = (count == '0);
	assign full = (count == fifoCntLen'(fifoDepth));

	countBound: assert property (@(posedge clk) disable iff (reset)
		count <= fifoCntLen'(fifoDepth));

endmodule

/* logic/uartWbRegs.sv */
/*
 * Wishbone classic register block
 * data, status and divisor registers; single-cycle ack with no
 * wait states, sticky overrun flag, FIFO push/pop strobes
 */

`timescale 1ns/100ps

module uartWbRegs import uartPkg::*; (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [regAddrLen-1:0] adr,
	input logic [dataBits-1:0] datIn,
	input logic [dataBits-1:0] rxData,	// rx fifo head
	input logic rxEmpty,
	input logic rxFull,
	input logic txEmpty,
	input logic txFull,
	input logic rxDoneTick,
	output logic [dataBits-1:0] datOut,
	output logic ack,
	output logic rxPop,
	output logic txPush,
	output logic [dataBits-1:0] txData,
	output logic [divLen-1:0] div
);

	logic req;				// first cycle of a bus request
	logic overrun;				// sticky, cleared by status read
	logic [dataBits-1:0] stat;

	// masked by ack so a held stb cannot start a second access
	assign req = cyc && stb && !ack;

	assign rxPop = req && !we && (adr == addrData) && !rxEmpty;
	assign txPush = req && we && (adr == addrData) && !txFull;	// full drops it
	assign txData = datIn;

	always_comb
	begin
		stat = '0;
		stat[statRxEmpty] = rxEmpty;
		stat[statRxFull] = rxFull;
		stat[statTxEmpty] = txEmpty;
		stat[statTxFull] = txFull;
		stat[statOverrun] = overrun;
	end

	////////////////////////////////////////////////////////////
	// ack, read mux, divisor and overrun
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			datOut <= '0;
			div <= divReset;
			overrun <= 1'b0;
		end
		else
		begin
			ack <= req;
			if (req && we && (adr == addrDiv))
				div <= divLen'(datIn);		// low byte, upper bits cleared
			if (req && !we)
				case (adr)
					addrData: datOut <= rxEmpty ? '0 : rxData;
					addrStat: datOut <= stat;
					addrDiv: datOut <= div[dataBits-1:0];
					default: datOut <= '0;
				endcase
			// a lost byte wins over a clearing read in the same cycle
			if (rxDoneTick && rxFull)
				overrun <= 1'b1;
			else if (req && !we && (adr == addrStat))
				overrun <= 1'b0;
		end
	end

	ackSingle: assert property (@(posedge clk) disable iff (reset)
		ack |=> !ack);

endmodule

/* logic/uartTop.sv */
/*
 * UART peripheral top level
 * tick generator, receiver, transmitter, one FIFO per direction
 * and the Wishbone register block
 */

`timescale 1ns/100ps

module uartTop import uartPkg::*; (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [regAddrLen-1:0] adr,
	input logic [dataBits-1:0] datIn,
	output logic [dataBits-1:0] datOut,
	output logic ack,
	input logic rx,
	output logic tx
);

	logic sTick;
	logic [divLen-1:0] div;
	logic rxDoneTick, rxPop, rxEmpty, rxFull;
	logic [dataBits-1:0] recData, rxData;
	logic txPush, txPop, txEmpty, txFull;
	logic [dataBits-1:0] txData, txHead;

	baudGen baudGen (.clk, .reset, .div, .sTick);

	uartRec uartRec (.clk, .reset, .sTick, .rx, .rxDoneTick, .dOut(recData));

	uartFifo rxFifo (.clk, .reset, .push(rxDoneTick), .pop(rxPop), .dIn(recData),
		.dOut(rxData), .empty(rxEmpty), .full(rxFull));

	uartFifo txFifo (.clk, .reset, .push(txPush), .pop(txPop), .dIn(txData),
		.dOut(txHead), .empty(txEmpty), .full(txFull));

	uartTrans uartTrans (.clk, .reset, .sTick, .txEmpty, .dIn(txHead), .txPop, .tx);

	uartWbRegs uartWbRegs (.clk, .reset, .cyc, .stb, .we, .adr, .datIn,
		.rxData, .rxEmpty, .rxFull, .txEmpty, .txFull, .rxDoneTick,
		.datOut, .ack, .rxPop, .txPush, .txData, .div);

endmodule

/* test/uartTb.sv */
/*
 * UART peripheral testbench
 * Wishbone bus driver, serial line driver with loopback mux and a
 * queue model of the RX FIFO; random bytes from a fixed seed
 */

`timescale 1ns/100ps

module uartTb import uartPkg::*; ();

	localparam int totalFrames = 12 + 10 + 4 + 17;	// all frames in the run
	localparam int maxDiv = 9;
	localparam longint timeoutNs = longint'(totalFrames) * 160 * maxDiv * 10 * 2 + 100000;
	localparam int ackLimit = 8;		// cycles before a missing ack is fatal
	localparam int pollLimit = 2000;	// status reads before giving up

	logic clk, reset;
	logic cyc, stb, we;
	logic [regAddrLen-1:0] adr;
	logic [dataBits-1:0] datIn, datOut;
	logic ack;
	logic rxDrv, rxLine, txLine;
	logic loopback;				// 1 feeds tx back into rx

	int seed = 92043;
	int failCount = 0;
	int curDiv;				// divisor the line driver runs at
	logic [dataBits-1:0] rxModel [$];	// expected RX FIFO contents
	logic ovrModel;				// expected sticky overrun

	assign rxLine = loopback ? txLine : rxDrv;

	uartTop dut (.clk, .reset, .cyc, .stb, .we, .adr, .datIn, .datOut, .ack,
		.rx(rxLine), .tx(txLine));

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// error handling and checks
	////////////////////////////////////////////////////////////
	task automatic stopOnError(input string msg);
		failCount++;
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkEq(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
			stopOnError($sformatf("Mismatch in %s: expected %02h, actual %02h",
				name, expected, actual));
	endtask

	// status byte as the register map defines it
	function automatic logic [7:0] expectedStat(input int rxCnt, input logic ovr,
		input int txCnt);
		logic [7:0] s;
		s = '0;
		s[statRxEmpty] = (rxCnt == 0);
		s[statRxFull] = (rxCnt == fifoDepth);
		s[statTxEmpty] = (txCnt == 0);
		s[statTxFull] = (txCnt == fifoDepth);
		s[statOverrun] = ovr;
		return s;
	endfunction

	function automatic logic [7:0] randByte();
		return 8'($random(seed));
	endfunction

	// bytes beyond the FIFO depth are lost and flag overrun
	function automatic void pushModel(input logic [7:0] b);
		if (rxModel.size() < fifoDepth)
			rxModel.push_back(b);
		else
			ovrModel = 1'b1;
	endfunction

	////////////////////////////////////////////////////////////
	// Wishbone master
	////////////////////////////////////////////////////////////
	task automatic waitAck(output logic [7:0] data);
		int n;
		n = 0;
		@(negedge clk);
		while (!ack)
		begin
			n++;
			if (n > ackLimit)
				stopOnError("Wishbone slave never raised ack");
			@(negedge clk);
		end
		checkEq("ack latency", 8'd1, 8'(n));	// no wait states
		data = datOut;
	endtask

	task automatic endCycle();
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		@(negedge clk);
		checkEq("single ack", 8'd0, {7'd0, ack});
	endtask

	task automatic wbWrite(input logic [regAddrLen-1:0] a, input logic [7:0] d);
		logic [7:0] unused;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b1;
		adr <= a;
		datIn <= d;
		waitAck(unused);
		endCycle();
	endtask

	task automatic wbRead(input logic [regAddrLen-1:0] a, output logic [7:0] d);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b0;
		adr <= a;
		waitAck(d);
		endCycle();
	endtask

	// poll status until one flag reaches the wanted level
	task automatic waitStatus(input int bitPos, input logic level, input string what);
		int n;
		logic [7:0] s;
		n = 0;
		wbRead(addrStat, s);
		while (s[bitPos] !== level)
		begin
			n++;
			if (n > pollLimit)
				stopOnError({"status flag never changed while waiting for ", what});
			wbRead(addrStat, s);
		end
	endtask

	////////////////////////////////////////////////////////////
	// serial line driver
	////////////////////////////////////////////////////////////
	task automatic driveBit(input logic v);
		@(posedge clk);
		rxDrv <= v;
		repeat (16 * curDiv - 1) @(posedge clk);	// 16 ticks of div clocks
	endtask

	task automatic sendFrame(input logic [7:0] b);
		int i;
		driveBit(1'b0);			// start
		for (i = 0; i < dataBits; i++)
			driveBit(b[i]);		// LSB first
		driveBit(1'b1);			// stop
	endtask

	// n frames in, n bytes out in order, then an empty read
	task automatic runReceive(input int n, input string name);
		int i;
		logic [7:0] b;
		logic [7:0] v;
		for (i = 0; i < n; i++)
		begin
			b = randByte();
			pushModel(b);
			sendFrame(b);
		end
		for (i = 0; i < n; i++)
		begin
			wbRead(addrData, v);
			checkEq(name, rxModel.pop_front(), v);
		end
		wbRead(addrData, v);
		checkEq({name, " empty read"}, 8'd0, v);
		wbRead(addrStat, v);
		checkEq({name, " status"}, expectedStat(0, 1'b0, 0), v);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		int i;
		int newDiv;
		logic [7:0] b;
		logic [7:0] v;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		rxDrv = 1'b1;			// idle line
		loopback = 1'b0;
		ovrModel = 1'b0;
		curDiv = int'(divReset);
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		// reset values
		wbRead(addrStat, v);
		checkEq("reset status", expectedStat(0, 1'b0, 0), v);
		wbRead(addrDiv, v);
		checkEq("reset divisor", 8'(divReset), v);
		checkEq("reset tx line", 8'd1, {7'd0, txLine});

		runReceive(12, "receive");

		// loopback, tx drives rx
		@(posedge clk);
		loopback <= 1'b1;
		for (i = 0; i < 10; i++)
		begin
			b = randByte();
			pushModel(b);
			wbWrite(addrData, b);
		end
		for (i = 0; i < 10; i++)
		begin
			waitStatus(statRxEmpty, 1'b0, "loopback byte");
			wbRead(addrData, v);
			checkEq("loopback", rxModel.pop_front(), v);
		end
		wbRead(addrStat, v);
		checkEq("loopback status", expectedStat(0, 1'b0, 0), v);
		@(posedge clk);
		loopback <= 1'b0;

		// new rate, 2 to 9
		newDiv = 2 + int'($unsigned($random(seed)) % 8);
		wbWrite(addrDiv, 8'(newDiv));
		wbRead(addrDiv, v);
		checkEq("divisor readback", 8'(newDiv), v);
		curDiv = newDiv;
		runReceive(4, "receive new rate");

		// overrun, one frame more than the FIFO holds
		for (i = 0; i < fifoDepth + 1; i++)
		begin
			b = randByte();
			pushModel(b);
			sendFrame(b);
		end
		wbRead(addrStat, v);
		checkEq("overrun status", expectedStat(fifoDepth, ovrModel, 0), v);
		ovrModel = 1'b0;		// cleared by that read
		for (i = 0; i < fifoDepth; i++)
		begin
			wbRead(addrData, v);
			checkEq("overrun data", rxModel.pop_front(), v);
		end
		wbRead(addrStat, v);
		checkEq("overrun cleared", expectedStat(0, ovrModel, 0), v);

		if (failCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// watchdog, frame count at the slowest divisor with margin
	initial
	begin
		#(timeoutNs);
		stopOnError("timeout: the test sequence did not finish in time");
	end

endmodule

/* list.f */
logic/uartPkg.sv
logic/baudGen.sv
logic/uartRec.sv
logic/uartTrans.sv
logic/uartFifo.sv
logic/uartWbRegs.sv
logic/uartTop.sv
test/uartTb.sv

/* run.sh */
#!/bin/sh
# build and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module uartTb -f list.f --Mdir build -o uartSim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./build/uartSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi
